// File: hw/decoding_graph_macros.svh
`ifndef DECODING_GRAPH_MACROS_SVH
`define DECODING_GRAPH_MACROS_SVH

// grid of one device slice
`define GRID_WIDTH_X 4 // rows per layer
`define GRID_WIDTH_Z 2 // columns per layer
`define LAYER_COUNT 3 // physical layers
`define NUM_CONTEXTS 2 // logical contexts mapped onto the same layers

`define MAX_WEIGHT 2 // every edge has this weight
`define FPGA_ID 1
`define NEIGHBOR_COUNT 6

// address field widths, u spans all contexts
`define X_BIT_WIDTH ($clog2(`GRID_WIDTH_X))
`define Z_BIT_WIDTH ($clog2(`GRID_WIDTH_Z))
`define U_BIT_WIDTH ($clog2(`LAYER_COUNT * `NUM_CONTEXTS))
`define FPGA_BIT_WIDTH ($clog2(`FPGA_ID + 1))
`define CONTEXT_BIT_WIDTH ($clog2(`NUM_CONTEXTS))
`define LINK_BIT_WIDTH ($clog2(`MAX_WEIGHT + 1))
`define ADDRESS_WIDTH (`X_BIT_WIDTH + `Z_BIT_WIDTH + `U_BIT_WIDTH + `FPGA_BIT_WIDTH + 1)

`define PU_COUNT_PER_LAYER (`GRID_WIDTH_X * `GRID_WIDTH_Z)
`define PU_COUNT (`PU_COUNT_PER_LAYER * `LAYER_COUNT)
`define PU_INDEX(k, i, j) ((k) * `PU_COUNT_PER_LAYER + (i) * `GRID_WIDTH_Z + (j))

`endif

// File: hw/decoding_graph_pkg.sv
`include "decoding_graph_macros.svh"

package decoding_graph_pkg;

    // level coded stage, held by the environment
    typedef enum logic [2:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROW                = 3'd2,
        STAGE_MERGE               = 3'd3,
        STAGE_WRITE_TO_MEM        = 3'd4
    } stage_t;

    typedef logic [`CONTEXT_BIT_WIDTH-1:0] context_t;
    typedef logic [`U_BIT_WIDTH-1:0] u_coord_t;
    typedef logic [`X_BIT_WIDTH-1:0] x_coord_t;
    typedef logic [`Z_BIT_WIDTH-1:0] z_coord_t;
    typedef logic [`FPGA_BIT_WIDTH-1:0] fpga_id_t;

    // global address of one unit, z in the low bits
    typedef struct packed {
        logic     is_real; // set for every real unit so no address is zero
        fpga_id_t fpga_id;
        u_coord_t u;
        x_coord_t x;
        z_coord_t z;
    } pu_address_t;

    // fields when the address is built, flat word when roots are compared
    typedef union packed {
        pu_address_t                 fields;
        logic [`ADDRESS_WIDTH-1:0]   flat;
    } pu_address_u;

    // what a unit shows to each of its neighbors
    typedef struct packed {
        pu_address_u root;
        logic        defect;
    } link_req_t;

    // neighbor index of the grown and neighbor vectors
    typedef enum logic [2:0] {
        DIR_NORTH = 3'd0, // row i-1
        DIR_SOUTH = 3'd1, // row i+1
        DIR_WEST  = 3'd2, // column j-1
        DIR_EAST  = 3'd3, // column j+1
        DIR_DOWN  = 3'd4, // layer k-1
        DIR_UP    = 3'd5  // layer k+1
    } dir_e;

endpackage

// File: hw/context_sequencer.sv
`include "decoding_graph_macros.svh"

module context_sequencer
    import decoding_graph_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  stage_t                       global_stage_i,
    output context_t                     context_o,
    output u_coord_t [`LAYER_COUNT-1:0]  layer_u_o
);

    context_t context_q;
    context_t context_dly_q; // address fields follow this copy
    u_coord_t layer_base;

    // one step per write-to-memory cycle, wraps after the last context
    always_ff @(posedge clk) begin
        if (reset) begin
            context_q <= '0;
        end else if (global_stage_i == STAGE_WRITE_TO_MEM) begin
            if (context_q == context_t'(`NUM_CONTEXTS - 1)) begin
                context_q <= '0;
            end else begin
                context_q <= context_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            context_dly_q <= '0;
        end else begin
            context_dly_q <= context_q;
        end
    end

    assign context_o = context_q;
    assign layer_base = u_coord_t'(context_dly_q * `LAYER_COUNT); // first u of this context

    // odd contexts walk the stack the other way round
    always_comb begin
        for (int l = 0; l < `LAYER_COUNT; l++) begin
            if (context_dly_q[0]) begin
                layer_u_o[l] = layer_base + u_coord_t'(`LAYER_COUNT - 1 - l);
            end else begin
                layer_u_o[l] = layer_base + u_coord_t'(l);
            end
        end
    end

endmodule

// File: hw/neighbor_link.sv
`include "decoding_graph_macros.svh"

// growth counter of one edge between units a and b
module neighbor_link
    import decoding_graph_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  stage_t global_stage_i,
    input  logic   a_defect_i,
    input  logic   b_defect_i,
    output logic   fully_grown_o
);

    logic [`LINK_BIT_WIDTH-1:0] weight_q;
    logic                       at_max;
    logic                       grow_en;

    assign at_max = (weight_q == `LINK_BIT_WIDTH'(`MAX_WEIGHT));

    // the edge grows from either side that holds a defect
    assign grow_en = (global_stage_i == STAGE_GROW) && (a_defect_i || b_defect_i) && !at_max;

    always_ff @(posedge clk) begin
        if (reset) begin
            weight_q <= '0;
        end else if (global_stage_i == STAGE_MEASUREMENT_LOADING) begin
            weight_q <= '0; // fresh graph for every round of measurements
        end else if (grow_en) begin
            weight_q <= weight_q + 1'b1;
        end
    end

    assign fully_grown_o = at_max; // both endpoints see the same flag

endmodule

// File: hw/processing_unit.sv
`include "decoding_graph_macros.svh"

module processing_unit
    import decoding_graph_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  stage_t                            global_stage_i,
    input  logic                              measurement_i,
    output logic                              measurement_o,
    input  x_coord_t                          x_i,
    input  z_coord_t                          z_i,
    input  u_coord_t                          u_i,
    input  logic [`NEIGHBOR_COUNT-1:0]        grown_i,
    input  link_req_t [`NEIGHBOR_COUNT-1:0]   neighbor_i,
    output link_req_t                         neighbor_o,
    output pu_address_u                       root_o,
    output logic                              busy_o
);

    logic        measurement_q; // defect bit of this unit
    pu_address_u own_addr;
    pu_address_u root_q;
    pu_address_u root_min;
    pu_address_u root_d;
    logic        busy_q;

    // one layer of the measurement shift chain
    always_ff @(posedge clk) begin
        if (reset) begin
            measurement_q <= 1'b0;
        end else if (global_stage_i == STAGE_MEASUREMENT_LOADING) begin
            measurement_q <= measurement_i;
        end
    end

    assign measurement_o = measurement_q;

    always_comb begin
        own_addr.fields.is_real = 1'b1;
        own_addr.fields.fpga_id = fpga_id_t'(`FPGA_ID);
        own_addr.fields.u       = u_i; // depends on context
        own_addr.fields.x       = x_i;
        own_addr.fields.z       = z_i;
    end

    // smallest root seen across fully grown edges
    always_comb begin
        root_min = root_q;
        for (int d = 0; d < `NEIGHBOR_COUNT; d++) begin
            if (grown_i[d] && (neighbor_i[d].root.flat < root_min.flat)) begin
                root_min = neighbor_i[d].root;
            end
        end
    end

    always_comb begin
        case (global_stage_i)
            STAGE_MEASUREMENT_LOADING: root_d = own_addr; // every unit starts as its own root
            STAGE_MERGE:               root_d = root_min;
            default:                   root_d = root_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            root_q <= '0;
            busy_q <= 1'b0;
        end else begin
            root_q <= root_d;
            busy_q <= (root_d.flat != root_q.flat); // high for one cycle per change
        end
    end

    assign neighbor_o.root   = root_q;
    assign neighbor_o.defect = measurement_q;
    assign root_o            = root_q;
    assign busy_o            = busy_q;

endmodule

// File: hw/root_collector.sv
`include "decoding_graph_macros.svh"

module root_collector
    import decoding_graph_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  stage_t                        global_stage_i,
    input  pu_address_u [`PU_COUNT-1:0]   roots_i,
    input  logic [`PU_COUNT-1:0]          busy_i,
    output pu_address_u [`PU_COUNT-1:0]   roots_o,
    output logic [`PU_COUNT-1:0]          busy_o,
    output logic                          converged_o
);

    pu_address_u [`PU_COUNT-1:0] roots_q;
    logic [`PU_COUNT-1:0]        busy_q;
    logic                        any_busy;
    logic [1:0]                  quiet_cnt_q; // merge cycles in a row with no busy unit

    assign any_busy = |busy_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            roots_q <= '0;
            busy_q  <= '0;
        end else begin
            roots_q <= roots_i;
            busy_q  <= busy_i;
        end
    end

    // first merge cycle still shows grow-stage busy flags, so wait for two
    always_ff @(posedge clk) begin
        if (reset) begin
            quiet_cnt_q <= '0;
        end else if ((global_stage_i != STAGE_MERGE) || any_busy) begin
            quiet_cnt_q <= '0;
        end else if (quiet_cnt_q != 2'd2) begin
            quiet_cnt_q <= quiet_cnt_q + 1'b1;
        end
    end

    assign roots_o     = roots_q;
    assign busy_o      = busy_q;
    assign converged_o = (global_stage_i == STAGE_MERGE) && (quiet_cnt_q == 2'd2);

endmodule

// File: hw/decoding_graph_top.sv
`include "decoding_graph_macros.svh"

module decoding_graph_top
    import decoding_graph_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  stage_t                            global_stage_i,
    input  logic [`PU_COUNT_PER_LAYER-1:0]    measurements_i,
    output pu_address_u [`PU_COUNT-1:0]       roots_o,
    output logic [`PU_COUNT-1:0]              busy_o,
    output logic                              converged_o,
    output context_t                          context_o
);

    u_coord_t [`LAYER_COUNT-1:0] layer_u;
    link_req_t                   unit_out [`LAYER_COUNT][`GRID_WIDTH_X][`GRID_WIDTH_Z];
    logic                        meas_out [`LAYER_COUNT][`GRID_WIDTH_X][`GRID_WIDTH_Z];
    pu_address_u [`PU_COUNT-1:0] unit_root;
    logic [`PU_COUNT-1:0]        unit_busy;

    // edge arrays carry one extra slot, entry n sits before unit n
    logic ns_grown [`LAYER_COUNT][`GRID_WIDTH_X+1][`GRID_WIDTH_Z];
    logic ew_grown [`LAYER_COUNT][`GRID_WIDTH_X][`GRID_WIDTH_Z+1];
    logic ud_grown [`LAYER_COUNT+1][`GRID_WIDTH_X][`GRID_WIDTH_Z];

    context_sequencer u_seq (
        .clk            (clk),
        .reset          (reset),
        .global_stage_i (global_stage_i),
        .context_o      (context_o),
        .layer_u_o      (layer_u)
    );

    for (genvar k = 0; k < `LAYER_COUNT; k++) begin : pu_k
        for (genvar i = 0; i < `GRID_WIDTH_X; i++) begin : pu_i
            for (genvar j = 0; j < `GRID_WIDTH_Z; j++) begin : pu_j
                // neighbor positions, clamped at the border where grown stays low
                localparam int row_n = (i > 0) ? i - 1 : i;
                localparam int row_s = (i < `GRID_WIDTH_X - 1) ? i + 1 : i;
                localparam int col_w = (j > 0) ? j - 1 : j;
                localparam int col_e = (j < `GRID_WIDTH_Z - 1) ? j + 1 : j;
                localparam int lay_d = (k > 0) ? k - 1 : k;
                localparam int lay_u = (k < `LAYER_COUNT - 1) ? k + 1 : k;

                logic                            meas_in;
                logic [`NEIGHBOR_COUNT-1:0]      grown;
                link_req_t [`NEIGHBOR_COUNT-1:0] nbr_in;

                if (k == `LAYER_COUNT - 1) begin : g_top
                    assign meas_in = measurements_i[i * `GRID_WIDTH_Z + j]; // fresh round enters here
                end else begin : g_below
                    assign meas_in = meas_out[k + 1][i][j];
                end

                assign grown[DIR_NORTH] = ns_grown[k][i][j];
                assign grown[DIR_SOUTH] = ns_grown[k][i + 1][j];
                assign grown[DIR_WEST]  = ew_grown[k][i][j];
                assign grown[DIR_EAST]  = ew_grown[k][i][j + 1];
                assign grown[DIR_DOWN]  = ud_grown[k][i][j];
                assign grown[DIR_UP]    = ud_grown[k + 1][i][j];

                assign nbr_in[DIR_NORTH] = unit_out[k][row_n][j];
                assign nbr_in[DIR_SOUTH] = unit_out[k][row_s][j];
                assign nbr_in[DIR_WEST]  = unit_out[k][i][col_w];
                assign nbr_in[DIR_EAST]  = unit_out[k][i][col_e];
                assign nbr_in[DIR_DOWN]  = unit_out[lay_d][i][j];
                assign nbr_in[DIR_UP]    = unit_out[lay_u][i][j];

                processing_unit u_pu (
                    .clk            (clk),
                    .reset          (reset),
                    .global_stage_i (global_stage_i),
                    .measurement_i  (meas_in),
                    .measurement_o  (meas_out[k][i][j]),
                    .x_i            (x_coord_t'(i)),
                    .z_i            (z_coord_t'(j)),
                    .u_i            (layer_u[k]),
                    .grown_i        (grown),
                    .neighbor_i     (nbr_in),
                    .neighbor_o     (unit_out[k][i][j]),
                    .root_o         (unit_root[`PU_INDEX(k, i, j)]),
                    .busy_o         (unit_busy[`PU_INDEX(k, i, j)])
                );
            end
        end
    end

    // north-south edges between rows i-1 and i
    for (genvar k = 0; k < `LAYER_COUNT; k++) begin : ns_k
        for (genvar i = 0; i <= `GRID_WIDTH_X; i++) begin : ns_i
            for (genvar j = 0; j < `GRID_WIDTH_Z; j++) begin : ns_j
                if (i == 0 || i == `GRID_WIDTH_X) begin : g_border
                    assign ns_grown[k][i][j] = 1'b0;
                end else begin : g_link
                    neighbor_link u_link (
                        .clk            (clk),
                        .reset          (reset),
                        .global_stage_i (global_stage_i),
                        .a_defect_i     (unit_out[k][i - 1][j].defect),
                        .b_defect_i     (unit_out[k][i][j].defect),
                        .fully_grown_o  (ns_grown[k][i][j])
                    );
                end
            end
        end
    end

    // east-west edges between columns j-1 and j
    for (genvar k = 0; k < `LAYER_COUNT; k++) begin : ew_k
        for (genvar i = 0; i < `GRID_WIDTH_X; i++) begin : ew_i
            for (genvar j = 0; j <= `GRID_WIDTH_Z; j++) begin : ew_j
                if (j == 0 || j == `GRID_WIDTH_Z) begin : g_border
                    assign ew_grown[k][i][j] = 1'b0;
                end else begin : g_link
                    neighbor_link u_link (
                        .clk            (clk),
                        .reset          (reset),
                        .global_stage_i (global_stage_i),
                        .a_defect_i     (unit_out[k][i][j - 1].defect),
                        .b_defect_i     (unit_out[k][i][j].defect),
                        .fully_grown_o  (ew_grown[k][i][j])
                    );
                end
            end
        end
    end

    // up-down edges between layers k-1 and k
    for (genvar k = 0; k <= `LAYER_COUNT; k++) begin : ud_k
        for (genvar i = 0; i < `GRID_WIDTH_X; i++) begin : ud_i
            for (genvar j = 0; j < `GRID_WIDTH_Z; j++) begin : ud_j
                if (k == 0 || k == `LAYER_COUNT) begin : g_border
                    assign ud_grown[k][i][j] = 1'b0; // no support layers in this slice
                end else begin : g_link
                    neighbor_link u_link (
                        .clk            (clk),
                        .reset          (reset),
                        .global_stage_i (global_stage_i),
                        .a_defect_i     (unit_out[k - 1][i][j].defect),
                        .b_defect_i     (unit_out[k][i][j].defect),
                        .fully_grown_o  (ud_grown[k][i][j])
                    );
                end
            end
        end
    end

    root_collector u_collect (
        .clk            (clk),
        .reset          (reset),
        .global_stage_i (global_stage_i),
        .roots_i        (unit_root),
        .busy_i         (unit_busy),
        .roots_o        (roots_o),
        .busy_o         (busy_o),
        .converged_o    (converged_o)
    );

endmodule

// File: tests/tb_decoding_graph.sv
`include "decoding_graph_macros.svh"

module tb_decoding_graph import decoding_graph_pkg::*; ();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int MERGE_LIMIT     = 4 * `PU_COUNT; // generous bound on the merge latency
    localparam int RUN_CYCLES      = `LAYER_COUNT + `MAX_WEIGHT + MERGE_LIMIT + 4;
    localparam int RUN_COUNT       = 6; // decode runs over all tests
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + RUN_COUNT * RUN_CYCLES + 20);
    localparam logic [31:0] RANDOM_SEED = 32'h0550_d1a2;

    logic                           clk;
    logic                           reset;
    stage_t                         stage;
    logic [`PU_COUNT_PER_LAYER-1:0] measurements;
    pu_address_u [`PU_COUNT-1:0]    roots;
    logic [`PU_COUNT-1:0]           busy;
    logic                           converged;
    context_t                       context_cnt;

    logic                      defect_map [`PU_COUNT]; // indexed like the DUT's unit order
    logic [`ADDRESS_WIDTH-1:0] model_root [`PU_COUNT];

    decoding_graph_top dut (
        .clk            (clk),
        .reset          (reset),
        .global_stage_i (stage),
        .measurements_i (measurements),
        .roots_o        (roots),
        .busy_o         (busy),
        .converged_o    (converged),
        .context_o      (context_cnt)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_now(string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(string test_name, string what, logic [63:0] expected,
                               logic [63:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    // is_real, fpga id, u, x, z from the most significant bit down
    function automatic logic [`ADDRESS_WIDTH-1:0] unit_address(int k, int i, int j, int ctx);
        int u;
        int word;
        u = ((ctx % 2) == 1) ? (`LAYER_COUNT - 1 - k) : k;
        u = u + ctx * `LAYER_COUNT;
        word = 1 << (`ADDRESS_WIDTH - 1);
        word = word | (`FPGA_ID << (`U_BIT_WIDTH + `X_BIT_WIDTH + `Z_BIT_WIDTH));
        word = word | (u << (`X_BIT_WIDTH + `Z_BIT_WIDTH));
        word = word | (i << `Z_BIT_WIDTH) | j;
        return word[`ADDRESS_WIDTH-1:0];
    endfunction

    // flat index of the neighbor in direction d, or -1 past the grid edge
    function automatic int neighbor_index(int k, int i, int j, int d);
        int nk;
        int ni;
        int nj;
        nk = k;
        ni = i;
        nj = j;
        case (d)
            0:       ni = i - 1; // north
            1:       ni = i + 1; // south
            2:       nj = j - 1; // west
            3:       nj = j + 1; // east
            4:       nk = k - 1; // down
            default: nk = k + 1; // up
        endcase
        if (ni < 0 || ni >= `GRID_WIDTH_X || nj < 0 || nj >= `GRID_WIDTH_Z ||
            nk < 0 || nk >= `LAYER_COUNT) begin
            return -1;
        end
        return `PU_INDEX(nk, ni, nj);
    endfunction

    function automatic void clear_defects();
        for (int n = 0; n < `PU_COUNT; n++) begin
            defect_map[n] = 1'b0;
        end
    endfunction

    // links touching a defect are grown and each component takes its smallest address
    function automatic void build_model(int ctx);
        bit changed;
        int n;
        int m;
        for (int k = 0; k < `LAYER_COUNT; k++) begin
            for (int i = 0; i < `GRID_WIDTH_X; i++) begin
                for (int j = 0; j < `GRID_WIDTH_Z; j++) begin
                    model_root[`PU_INDEX(k, i, j)] = unit_address(k, i, j, ctx);
                end
            end
        end
        changed = 1'b1;
        while (changed) begin
            changed = 1'b0;
            for (int k = 0; k < `LAYER_COUNT; k++) begin
                for (int i = 0; i < `GRID_WIDTH_X; i++) begin
                    for (int j = 0; j < `GRID_WIDTH_Z; j++) begin
                        n = `PU_INDEX(k, i, j);
                        for (int d = 0; d < `NEIGHBOR_COUNT; d++) begin
                            m = neighbor_index(k, i, j, d);
                            if (m >= 0 && (defect_map[n] || defect_map[m]) &&
                                model_root[m] < model_root[n]) begin
                                model_root[n] = model_root[m];
                                changed = 1'b1;
                            end
                        end
                    end
                end
            end
        end
    endfunction

    function automatic logic [`PU_COUNT_PER_LAYER-1:0] layer_bits(int k);
        logic [`PU_COUNT_PER_LAYER-1:0] bits;
        for (int i = 0; i < `GRID_WIDTH_X; i++) begin
            for (int j = 0; j < `GRID_WIDTH_Z; j++) begin
                bits[i * `GRID_WIDTH_Z + j] = defect_map[`PU_INDEX(k, i, j)];
            end
        end
        return bits;
    endfunction

    // load, grow, merge until converged, then compare every root with the model
    task automatic run_decode(string test_name, int ctx);
        int cycles;
        build_model(ctx);
        for (int c = 0; c < `LAYER_COUNT; c++) begin
            @(posedge clk);
            stage        <= STAGE_MEASUREMENT_LOADING;
            measurements <= layer_bits(c); // first bit sinks to layer 0
        end
        for (int w = 0; w < `MAX_WEIGHT; w++) begin
            @(posedge clk);
            stage        <= STAGE_GROW;
            measurements <= '0;
        end
        @(posedge clk);
        stage <= STAGE_MERGE;
        cycles = 0;
        @(negedge clk);
        while (!converged && cycles < MERGE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!converged) begin
            fail_now($sformatf("%s: converged_o did not rise within %0d merge cycles",
                               test_name, MERGE_LIMIT));
        end
        for (int n = 0; n < `PU_COUNT; n++) begin
            check_equal(test_name, $sformatf("root of unit %0d", n),
                        64'(model_root[n]), 64'(roots[n].flat));
        end
        check_equal(test_name, "busy_o", 64'(0), 64'(busy));
        @(posedge clk);
        stage <= STAGE_IDLE;
    endtask

    task automatic test_after_reset();
        check_equal("after_reset", "context_o", 64'(0), 64'(context_cnt));
        for (int n = 0; n < `PU_COUNT; n++) begin
            check_equal("after_reset", $sformatf("root of unit %0d", n), 64'(0),
                        64'(roots[n].flat));
        end
        check_equal("after_reset", "busy_o", 64'(0), 64'(busy));
        check_equal("after_reset", "converged_o", 64'(0), 64'(converged));
    endtask

    task automatic test_no_defects();
        clear_defects();
        run_decode("no_defects", 0);
    endtask

    task automatic test_one_defect();
        clear_defects();
        defect_map[`PU_INDEX(0, 1, 1)] = 1'b1;
        run_decode("one_defect", 0);
    endtask

    task automatic test_two_defects();
        int a;
        int b;
        clear_defects();
        defect_map[`PU_INDEX(1, 0, 1)] = 1'b1; // rows 0 and 2 share row 1
        defect_map[`PU_INDEX(1, 2, 1)] = 1'b1;
        run_decode("two_defects_row", 0);
        a = int'($urandom % `PU_COUNT);
        b = int'($urandom % `PU_COUNT);
        if (b == a) begin
            b = (a + 1) % `PU_COUNT;
        end
        clear_defects();
        defect_map[a] = 1'b1;
        defect_map[b] = 1'b1;
        run_decode($sformatf("two_defects_random_%0d_%0d", a, b), 0);
    endtask

    task automatic test_context_switch();
        clear_defects();
        @(posedge clk);
        stage <= STAGE_WRITE_TO_MEM;
        @(posedge clk);
        stage <= STAGE_IDLE;
        @(negedge clk);
        check_equal("context_switch", "context_o", 64'(1), 64'(context_cnt));
        run_decode("context_odd", 1);
        @(posedge clk);
        stage <= STAGE_WRITE_TO_MEM;
        @(posedge clk);
        stage <= STAGE_IDLE;
        @(negedge clk);
        check_equal("context_wrap", "context_o", 64'(0), 64'(context_cnt));
        run_decode("context_wrap", 0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_now("run timed out before all tests finished");
    end

    initial begin
        reset        = 1'b1;
        stage        = STAGE_IDLE;
        measurements = '0;
        void'($urandom(RANDOM_SEED));
        clear_defects();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_after_reset();
        test_no_defects();
        test_one_defect();
        test_two_defects();
        test_context_switch();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: decoding_graph.f
+incdir+hw
hw/decoding_graph_pkg.sv
hw/context_sequencer.sv
hw/neighbor_link.sv
hw/processing_unit.sv
hw/root_collector.sv
hw/decoding_graph_top.sv
tests/tb_decoding_graph.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the decoding graph testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f decoding_graph.f --top-module tb_decoding_graph

# the simulator exits non-zero on a fatal error, keep its output for the search
sim_output=$(./obj_dir/Vtb_decoding_graph 2>&1 || true)
echo "$sim_output"

if grep -qx "TEST PASSED" <<< "$sim_output"; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi
